//--- common/udma_i2c_pkg.sv
`include "udma_i2c_settings.svh"

package udma_i2c_pkg;

	// ----------------------------------------------------------
	// Scalar types
	// ----------------------------------------------------------
	typedef logic [`L2_AWIDTH_NOAL-1:0] l2_addr_t;
	typedef logic [`TRANS_SIZE-1:0]     trans_size_t;
	typedef logic [4:0]                 cfg_addr_t;
	typedef logic [31:0]                cfg_data_t;
	typedef logic [7:0]                 byte_t;

	// ----------------------------------------------------------
	// Channel and L2 bundles
	// ----------------------------------------------------------
	typedef struct packed {
		l2_addr_t    startaddr;
		trans_size_t size;
		logic        continuous;
		logic        en;  // One cycle pulse
		logic        clr; // One cycle pulse
	} ch_cfg_t;

	typedef struct packed {
		logic        en;
		logic        pending;
		l2_addr_t    curr_addr;
		trans_size_t bytes_left;
	} ch_status_t;

	typedef struct packed {
		logic     req;
		logic     we;
		l2_addr_t addr;
		byte_t    wdata;
	} l2_req_t;

	// Byte shifter FSM
	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		LOW,
		HIGH
	} shift_state_e;

endpackage

//--- common/udma_i2c_settings.svh
`ifndef UDMA_I2C_SETTINGS_SVH
`define UDMA_I2C_SETTINGS_SVH

// Datapath widths
`define L2_AWIDTH_NOAL 12
`define TRANS_SIZE     16

// Register map of the configuration bus
`define REG_RX_SADDR 5'd0
`define REG_RX_SIZE  5'd1
`define REG_RX_CFG   5'd2
`define REG_TX_SADDR 5'd4
`define REG_TX_SIZE  5'd5
`define REG_TX_CFG   5'd6
`define REG_STATUS   5'd8
`define REG_SETUP    5'd9

`define I2C_CLKDIV 4 // Clocks per half SCL period

`endif

//--- compile.f
+incdir+common
common/udma_i2c_pkg.sv
udma_i2c/udma_i2c_reg_if.sv
udma_i2c/udma_channel.sv
udma_i2c/i2c_byte_shifter.sv
design/udma_i2c_top.sv
verif/udma_i2c_sva.sv
verif/udma_i2c_tb.sv

//--- design/udma_i2c_top.sv
module udma_i2c_top (
	input  logic                    clk_i,
	input  logic                    rstn_i,
	input  udma_i2c_pkg::cfg_data_t cfg_data_i,
	input  udma_i2c_pkg::cfg_addr_t cfg_addr_i,
	input  logic                    cfg_valid_i,
	input  logic                    cfg_rwn_i,
	output udma_i2c_pkg::cfg_data_t cfg_data_o,
	output logic                    cfg_ready_o,
	output udma_i2c_pkg::l2_req_t   l2_tx_req_o,
	input  udma_i2c_pkg::byte_t     l2_tx_rdata_i,
	output udma_i2c_pkg::l2_req_t   l2_rx_req_o,
	output logic                    scl_o,
	output logic                    sda_o,
	input  logic                    sda_i
);

	udma_i2c_pkg::ch_cfg_t    rx_cfg;
	udma_i2c_pkg::ch_cfg_t    tx_cfg;
	udma_i2c_pkg::ch_status_t rx_status;
	udma_i2c_pkg::ch_status_t tx_status;

	logic                do_rst;
	logic                busy;
	logic                al;
	logic                byte_req;
	logic                tx_fetch;
	logic                tx_rd_valid_q;
	logic                rx_valid;
	logic                rx_beat;
	udma_i2c_pkg::byte_t rx_byte;

	// ----------------------------------------------------------
	// L2 ports
	// ----------------------------------------------------------
	// One fetch per idle period since the shifter leaves IDLE on the returned byte
	assign tx_fetch = byte_req && tx_status.en && !tx_rd_valid_q;
	assign rx_beat  = rx_valid && rx_status.en; // Bytes are dropped while rx is off

	assign l2_tx_req_o = '{req: tx_fetch, we: 1'b0, addr: tx_status.curr_addr, wdata: '0};
	assign l2_rx_req_o = '{req: rx_beat, we: 1'b1, addr: rx_status.curr_addr, wdata: rx_byte};

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i)
			tx_rd_valid_q <= 1'b0;
		else
			tx_rd_valid_q <= tx_fetch; // L2 answers one cycle later
	end

	udma_i2c_reg_if reg_if_i (
		.clk_i         (clk_i),
		.rstn_i        (rstn_i),
		.cfg_data_i    (cfg_data_i),
		.cfg_addr_i    (cfg_addr_i),
		.cfg_valid_i   (cfg_valid_i),
		.cfg_rwn_i     (cfg_rwn_i),
		.cfg_data_o    (cfg_data_o),
		.cfg_ready_o   (cfg_ready_o),
		.rx_cfg_o      (rx_cfg),
		.tx_cfg_o      (tx_cfg),
		.rx_status_i   (rx_status),
		.tx_status_i   (tx_status),
		.do_rst_o      (do_rst),
		.status_busy_i (busy),
		.status_al_i   (al)
	);

	udma_channel rx_ch (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.cfg_i      (rx_cfg),
		.soft_rst_i (do_rst),
		.beat_i     (rx_beat),
		.status_o   (rx_status)
	);

	udma_channel tx_ch (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.cfg_i      (tx_cfg),
		.soft_rst_i (do_rst),
		.beat_i     (tx_fetch),
		.status_o   (tx_status)
	);

	i2c_byte_shifter shifter_i (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.soft_rst_i (do_rst),
		.byte_req_o (byte_req),
		.tx_valid_i (tx_rd_valid_q),
		.tx_byte_i  (l2_tx_rdata_i),
		.scl_o      (scl_o),
		.sda_o      (sda_o),
		.sda_i      (sda_i),
		.rx_valid_o (rx_valid),
		.rx_byte_o  (rx_byte),
		.busy_o     (busy),
		.al_o       (al)
	);

endmodule

//--- udma_i2c/i2c_byte_shifter.sv
`include "udma_i2c_settings.svh"

module i2c_byte_shifter (
	input  logic                clk_i,
	input  logic                rstn_i,
	input  logic                soft_rst_i,
	output logic                byte_req_o,
	input  logic                tx_valid_i,
	input  udma_i2c_pkg::byte_t tx_byte_i,
	output logic                scl_o,
	output logic                sda_o,
	input  logic                sda_i,
	output logic                rx_valid_o,
	output udma_i2c_pkg::byte_t rx_byte_o,
	output logic                busy_o,
	output logic                al_o
);

	localparam int unsigned      DIV_W    = $clog2(`I2C_CLKDIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`I2C_CLKDIV - 1);

	udma_i2c_pkg::shift_state_e state_q;
	logic [DIV_W-1:0]           div_cnt_q;
	logic [2:0]                 bit_cnt_q;
	udma_i2c_pkg::byte_t        tx_shift_q;
	udma_i2c_pkg::byte_t        rx_shift_q;
	logic                       rx_valid_q;
	logic                       al_q;

	logic div_end;
	logic sample;

	assign div_end = (div_cnt_q == DIV_LAST);
	assign sample  = (state_q == udma_i2c_pkg::HIGH) && div_end; // Last clock of SCL high

	assign byte_req_o = (state_q == udma_i2c_pkg::IDLE) && !soft_rst_i;
	assign busy_o     = (state_q != udma_i2c_pkg::IDLE);
	assign scl_o      = (state_q != udma_i2c_pkg::LOW);
	assign sda_o      = (state_q == udma_i2c_pkg::LOW || state_q == udma_i2c_pkg::HIGH) ?
		tx_shift_q[7] : 1'b1;
	assign rx_valid_o = rx_valid_q;
	assign rx_byte_o  = rx_shift_q;
	assign al_o       = al_q;

	// ----------------------------------------------------------
	// Bit sequencing FSM
	// ----------------------------------------------------------
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			state_q    <= udma_i2c_pkg::IDLE;
			div_cnt_q  <= '0;
			bit_cnt_q  <= '0;
			rx_valid_q <= 1'b0;
			al_q       <= 1'b0;
		end else if (soft_rst_i) begin
			state_q    <= udma_i2c_pkg::IDLE;
			div_cnt_q  <= '0;
			bit_cnt_q  <= '0;
			rx_valid_q <= 1'b0;
			al_q       <= 1'b0;
		end else begin
			rx_valid_q <= 1'b0;
			al_q       <= 1'b0;
			case (state_q)
				udma_i2c_pkg::IDLE: begin
					if (tx_valid_i)
						state_q <= udma_i2c_pkg::LOAD;
				end
				udma_i2c_pkg::LOAD: begin
					div_cnt_q <= '0;
					bit_cnt_q <= '0;
					state_q   <= udma_i2c_pkg::LOW;
				end
				udma_i2c_pkg::LOW: begin
					div_cnt_q <= div_end ? '0 : div_cnt_q + 1'b1;
					if (div_end)
						state_q <= udma_i2c_pkg::HIGH;
				end
				udma_i2c_pkg::HIGH: begin
					div_cnt_q <= div_end ? '0 : div_cnt_q + 1'b1;
					if (div_end) begin
						al_q      <= tx_shift_q[7] & ~sda_i; // Released the line but someone holds it low
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (bit_cnt_q == 3'd7) begin
							state_q    <= udma_i2c_pkg::IDLE;
							rx_valid_q <= 1'b1;
						end else begin
							state_q <= udma_i2c_pkg::LOW;
						end
					end
				end
				default: state_q <= udma_i2c_pkg::IDLE;
			endcase
		end
	end

	// Data shift registers
	always_ff @(posedge clk_i) begin
		if (state_q == udma_i2c_pkg::IDLE && tx_valid_i)
			tx_shift_q <= tx_byte_i;
		else if (sample)
			tx_shift_q <= {tx_shift_q[6:0], 1'b1};
		if (sample)
			rx_shift_q <= {rx_shift_q[6:0], sda_i}; // MSB arrives first
	end

endmodule

//--- udma_i2c/udma_channel.sv
module udma_channel (
	input  logic                     clk_i,
	input  logic                     rstn_i,
	input  udma_i2c_pkg::ch_cfg_t    cfg_i,
	input  logic                     soft_rst_i,
	input  logic                     beat_i,
	output udma_i2c_pkg::ch_status_t status_o
);

	logic                      en_q;
	logic                      pending_q;
	udma_i2c_pkg::l2_addr_t    curr_addr_q;
	udma_i2c_pkg::trans_size_t bytes_left_q;

	logic last_beat;
	logic reload;
	logic start;

	assign last_beat = en_q && beat_i &&
		(bytes_left_q == udma_i2c_pkg::trans_size_t'(1));

	// A finished transfer restarts when one is queued or the channel loops
	assign reload = last_beat && (pending_q || cfg_i.en || cfg_i.continuous);

	assign start = (!en_q && cfg_i.en) || reload;

	assign status_o.en         = en_q;
	assign status_o.pending    = pending_q;
	assign status_o.curr_addr  = curr_addr_q;
	assign status_o.bytes_left = bytes_left_q;

	// ----------------------------------------------------------
	// Address and byte counter
	// ----------------------------------------------------------
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			en_q         <= 1'b0;
			pending_q    <= 1'b0;
			curr_addr_q  <= '0;
			bytes_left_q <= '0;
		end else if (soft_rst_i) begin
			en_q         <= 1'b0;
			pending_q    <= 1'b0;
			curr_addr_q  <= '0;
			bytes_left_q <= '0;
		end else if (cfg_i.clr) begin
			en_q      <= 1'b0; // Stops at once and drops any queued start
			pending_q <= 1'b0;
		end else if (start) begin
			curr_addr_q  <= cfg_i.startaddr;
			bytes_left_q <= cfg_i.size;
			en_q         <= (cfg_i.size != '0);
			pending_q    <= 1'b0;
		end else if (en_q) begin
			if (beat_i) begin
				curr_addr_q  <= curr_addr_q + 1'b1;
				bytes_left_q <= bytes_left_q - 1'b1;
				if (last_beat)
					en_q <= 1'b0;
			end
			if (cfg_i.en)
				pending_q <= 1'b1; // Runs when the current transfer ends
		end
	end

endmodule

//--- udma_i2c/udma_i2c_reg_if.sv
`include "udma_i2c_settings.svh"

module udma_i2c_reg_if (
	input  logic                     clk_i,
	input  logic                     rstn_i,
	input  udma_i2c_pkg::cfg_data_t  cfg_data_i,
	input  udma_i2c_pkg::cfg_addr_t  cfg_addr_i,
	input  logic                     cfg_valid_i,
	input  logic                     cfg_rwn_i,
	output udma_i2c_pkg::cfg_data_t  cfg_data_o,
	output logic                     cfg_ready_o,
	output udma_i2c_pkg::ch_cfg_t    rx_cfg_o,
	output udma_i2c_pkg::ch_cfg_t    tx_cfg_o,
	input  udma_i2c_pkg::ch_status_t rx_status_i,
	input  udma_i2c_pkg::ch_status_t tx_status_i,
	output logic                     do_rst_o,
	input  logic                     status_busy_i,
	input  logic                     status_al_i
);

	udma_i2c_pkg::ch_cfg_t rx_cfg_q;
	udma_i2c_pkg::ch_cfg_t tx_cfg_q;
	logic                  do_rst_q;
	logic                  busy_q;
	logic                  al_q;

	// Set by a SADDR or SIZE write and cleared when the channel is started
	logic rx_saddr_wr_q;
	logic rx_size_wr_q;
	logic tx_saddr_wr_q;
	logic tx_size_wr_q;

	logic wr_en;
	logic rd_en;

	udma_i2c_pkg::l2_addr_t    rx_saddr_rd;
	udma_i2c_pkg::trans_size_t rx_size_rd;
	udma_i2c_pkg::l2_addr_t    tx_saddr_rd;
	udma_i2c_pkg::trans_size_t tx_size_rd;

	assign wr_en = cfg_valid_i & ~cfg_rwn_i;
	assign rd_en = cfg_valid_i & cfg_rwn_i;

	assign rx_cfg_o    = rx_cfg_q;
	assign tx_cfg_o    = tx_cfg_q;
	assign do_rst_o    = do_rst_q;
	assign cfg_ready_o = 1'b1; // No wait states on this bus

	// ----------------------------------------------------------
	// Register writes and sticky status
	// ----------------------------------------------------------
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			rx_cfg_q      <= '0;
			tx_cfg_q      <= '0;
			do_rst_q      <= 1'b0;
			busy_q        <= 1'b0;
			al_q          <= 1'b0;
			rx_saddr_wr_q <= 1'b0;
			rx_size_wr_q  <= 1'b0;
			tx_saddr_wr_q <= 1'b0;
			tx_size_wr_q  <= 1'b0;
		end else begin
			rx_cfg_q.en  <= 1'b0; // Start and clear last a single cycle
			rx_cfg_q.clr <= 1'b0;
			tx_cfg_q.en  <= 1'b0;
			tx_cfg_q.clr <= 1'b0;

			if (wr_en) begin
				case (cfg_addr_i)
					`REG_RX_SADDR: begin
						rx_cfg_q.startaddr <= cfg_data_i[`L2_AWIDTH_NOAL-1:0];
						rx_saddr_wr_q      <= 1'b1;
					end
					`REG_RX_SIZE: begin
						rx_cfg_q.size <= cfg_data_i[`TRANS_SIZE-1:0];
						rx_size_wr_q  <= 1'b1;
					end
					`REG_RX_CFG: begin
						rx_cfg_q.clr        <= cfg_data_i[5];
						rx_cfg_q.en         <= cfg_data_i[4];
						rx_cfg_q.continuous <= cfg_data_i[0];
						if (cfg_data_i[4]) begin
							rx_saddr_wr_q <= 1'b0;
							rx_size_wr_q  <= 1'b0;
						end
					end
					`REG_TX_SADDR: begin
						tx_cfg_q.startaddr <= cfg_data_i[`L2_AWIDTH_NOAL-1:0];
						tx_saddr_wr_q      <= 1'b1;
					end
					`REG_TX_SIZE: begin
						tx_cfg_q.size <= cfg_data_i[`TRANS_SIZE-1:0];
						tx_size_wr_q  <= 1'b1;
					end
					`REG_TX_CFG: begin
						tx_cfg_q.clr        <= cfg_data_i[5];
						tx_cfg_q.en         <= cfg_data_i[4];
						tx_cfg_q.continuous <= cfg_data_i[0];
						if (cfg_data_i[4]) begin
							tx_saddr_wr_q <= 1'b0;
							tx_size_wr_q  <= 1'b0;
						end
					end
					`REG_SETUP: do_rst_q <= cfg_data_i[0];
					default: ;
				endcase
			end

			if (rd_en && (cfg_addr_i == `REG_STATUS)) begin // Read clears both flags
				busy_q <= 1'b0;
				al_q   <= 1'b0;
			end else begin
				if (status_busy_i)
					busy_q <= 1'b1;
				if (status_al_i)
					al_q <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// Readback
	// ----------------------------------------------------------
	// An idle channel shows freshly written values until it is started
	assign rx_saddr_rd = (rx_saddr_wr_q && !rx_status_i.en) ?
		rx_cfg_q.startaddr : rx_status_i.curr_addr;
	assign rx_size_rd  = (rx_size_wr_q && !rx_status_i.en) ?
		rx_cfg_q.size : rx_status_i.bytes_left;
	assign tx_saddr_rd = (tx_saddr_wr_q && !tx_status_i.en) ?
		tx_cfg_q.startaddr : tx_status_i.curr_addr;
	assign tx_size_rd  = (tx_size_wr_q && !tx_status_i.en) ?
		tx_cfg_q.size : tx_status_i.bytes_left;

	always_comb begin
		cfg_data_o = '0;
		if (rd_en) begin
			case (cfg_addr_i)
				`REG_RX_SADDR: cfg_data_o[`L2_AWIDTH_NOAL-1:0] = rx_saddr_rd;
				`REG_RX_SIZE:  cfg_data_o[`TRANS_SIZE-1:0]     = rx_size_rd;
				`REG_RX_CFG: begin
					cfg_data_o[5] = rx_status_i.pending;
					cfg_data_o[4] = rx_status_i.en;
					cfg_data_o[0] = rx_cfg_q.continuous;
				end
				`REG_TX_SADDR: cfg_data_o[`L2_AWIDTH_NOAL-1:0] = tx_saddr_rd;
				`REG_TX_SIZE:  cfg_data_o[`TRANS_SIZE-1:0]     = tx_size_rd;
				`REG_TX_CFG: begin
					cfg_data_o[5] = tx_status_i.pending;
					cfg_data_o[4] = tx_status_i.en;
					cfg_data_o[0] = tx_cfg_q.continuous;
				end
				`REG_STATUS: begin
					cfg_data_o[1] = al_q;
					cfg_data_o[0] = busy_q;
				end
				`REG_SETUP: cfg_data_o[0] = do_rst_q;
				default: cfg_data_o = '0;
			endcase
		end
	end

endmodule

//--- verif/udma_i2c_sva.sv
`include "udma_i2c_settings.svh"

module udma_i2c_sva (
	input logic                      clk_i,
	input logic                      rstn_i,
	input logic                      soft_rst_i,
	input udma_i2c_pkg::ch_status_t  ch_status_i,
	input udma_i2c_pkg::trans_size_t ch_size_i,
	input logic                      rx_valid_i,
	input logic                      scl_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// A running channel never holds more bytes than it was started with
	bytes_left_in_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
		ch_status_i.en |-> (ch_status_i.bytes_left <= ch_size_i))
		else $error("bytes_left above the configured size");

	pending_needs_en: assert property (@(posedge clk_i) disable iff (!rstn_i)
		ch_status_i.pending |-> ch_status_i.en)
		else $error("pending set on a stopped channel");

	rx_valid_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
		rx_valid_i |=> !rx_valid_i)
		else $error("rx_valid_o held for more than one cycle");

	// Every SCL low phase lasts one divider period and then the line goes back high
	scl_low_phase: assert property (@(posedge clk_i) disable iff (!rstn_i || soft_rst_i)
		$fell(scl_i) |-> (!scl_i)[*`I2C_CLKDIV] ##1 scl_i)
		else $error("scl_o low phase differs from the divider period");

endmodule

// Each target ties off the ports that belong to the other one
bind udma_channel udma_i2c_sva channel_sva_i (
	.clk_i       (clk_i),
	.rstn_i      (rstn_i),
	.soft_rst_i  (soft_rst_i),
	.ch_status_i (status_o),
	.ch_size_i   (cfg_i.size),
	.rx_valid_i  (1'b0),
	.scl_i       (1'b1)
);

bind i2c_byte_shifter udma_i2c_sva shifter_sva_i (
	.clk_i       (clk_i),
	.rstn_i      (rstn_i),
	.soft_rst_i  (soft_rst_i),
	.ch_status_i ('0),
	.ch_size_i   ('0),
	.rx_valid_i  (rx_valid_o),
	.scl_i       (scl_o)
);

//--- verif/udma_i2c_tb.sv
`include "udma_i2c_settings.svh"

module udma_i2c_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// Loopback, arbitration, continuous, pending and soft reset traffic with idle windows
	localparam int TOTAL_BYTES = 40;
	localparam int TIMEOUT     = 100 * TOTAL_BYTES + 500;

	localparam udma_i2c_pkg::cfg_data_t ADDR_MASK = (32'd1 << `L2_AWIDTH_NOAL) - 1;
	localparam udma_i2c_pkg::cfg_data_t SIZE_MASK = (32'd1 << `TRANS_SIZE) - 1;

	logic                    clk_i;
	logic                    rstn_i;
	udma_i2c_pkg::cfg_data_t cfg_data_i;
	udma_i2c_pkg::cfg_addr_t cfg_addr_i;
	logic                    cfg_valid_i;
	logic                    cfg_rwn_i;
	udma_i2c_pkg::cfg_data_t cfg_data_o;
	logic                    cfg_ready_o;
	udma_i2c_pkg::l2_req_t   l2_tx_req_o;
	udma_i2c_pkg::l2_req_t   l2_rx_req_o;
	udma_i2c_pkg::byte_t     l2_tx_rdata_i;
	logic                    scl_o;
	logic                    sda_o;
	logic                    sda_i;
	logic                    pull_low;
	logic                    scl_prev = 1'b1;

	udma_i2c_pkg::byte_t   l2_mem [0:4095];
	udma_i2c_pkg::byte_t   tx_data [0:15]; // Bytes placed in the tx regions
	udma_i2c_pkg::byte_t   exp_rx [0:15];  // Bytes the rx region should end up with
	udma_i2c_pkg::l2_req_t tx_req_s;
	udma_i2c_pkg::l2_req_t rx_req_s;

	integer seed = 53;
	int     errors = 0;
	int     fails = 0;
	int     cycles = 0;
	int     fetches = 0;
	int     rx_writes = 0;
	int     scl_pulses = 0;

	assign sda_i = sda_o & ~pull_low; // Open drain line with an external pull-down

	udma_i2c_top udma_i2c_top_i (
		.clk_i         (clk_i),
		.rstn_i        (rstn_i),
		.cfg_data_i    (cfg_data_i),
		.cfg_addr_i    (cfg_addr_i),
		.cfg_valid_i   (cfg_valid_i),
		.cfg_rwn_i     (cfg_rwn_i),
		.cfg_data_o    (cfg_data_o),
		.cfg_ready_o   (cfg_ready_o),
		.l2_tx_req_o   (l2_tx_req_o),
		.l2_tx_rdata_i (l2_tx_rdata_i),
		.l2_rx_req_o   (l2_rx_req_o),
		.scl_o         (scl_o),
		.sda_o         (sda_o),
		.sda_i         (sda_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// L2 memory: reads answer one cycle later, writes land in the request cycle
	always begin
		@(negedge clk_i);
		tx_req_s = l2_tx_req_o;
		rx_req_s = l2_rx_req_o;
		if (rx_req_s.req && rx_req_s.we) begin
			l2_mem[rx_req_s.addr] = rx_req_s.wdata;
			rx_writes++;
		end else if (rx_req_s.req) begin
			fails++;
			$display("RX L2 port issued a read instead of a write");
		end
		if (tx_req_s.req && tx_req_s.we !== 1'b0) begin
			fails++;
			$display("TX L2 port issued a write instead of a read");
		end
		@(posedge clk_i);
		#1;
		if (tx_req_s.req) begin
			l2_tx_rdata_i = l2_mem[tx_req_s.addr];
			fetches++;
		end
	end

	// SCL pulses seen on the wire, counted on their falling edge
	always @(negedge clk_i) begin
		if (scl_prev && !scl_o)
			scl_pulses++;
		scl_prev = scl_o;
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Run stopped after %0d cycles with tests still waiting", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// Bus access and reference model
	// ----------------------------------------------------------
	task automatic write_reg(input udma_i2c_pkg::cfg_addr_t addr,
		input udma_i2c_pkg::cfg_data_t data);
		cfg_valid_i = 1'b1;
		cfg_rwn_i   = 1'b0;
		cfg_addr_i  = addr;
		cfg_data_i  = data;
		@(posedge clk_i);
		#1;
		cfg_valid_i = 1'b0;
	endtask

	task automatic read_reg(input udma_i2c_pkg::cfg_addr_t addr,
		output udma_i2c_pkg::cfg_data_t data);
		cfg_valid_i = 1'b1;
		cfg_rwn_i   = 1'b1;
		cfg_addr_i  = addr;
		@(negedge clk_i);
		data = cfg_data_o;
		if (cfg_ready_o !== 1'b1) begin
			fails++;
			$display("Configuration bus did not complete a read at offset %0d", addr);
		end
		@(posedge clk_i);
		#1;
		cfg_valid_i = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_i);
			#1;
		end
	endtask

	task automatic configure_channel(input udma_i2c_pkg::cfg_addr_t saddr_reg,
		input udma_i2c_pkg::l2_addr_t base, input int size, input udma_i2c_pkg::cfg_data_t cfg);
		write_reg(saddr_reg, udma_i2c_pkg::cfg_data_t'(base));
		write_reg(saddr_reg + 5'd1, size);
		write_reg(saddr_reg + 5'd2, cfg);
	endtask

	task automatic wait_channel_idle(input udma_i2c_pkg::cfg_addr_t cfg_reg);
		udma_i2c_pkg::cfg_data_t d;
		d = 32'h10;
		while (d[4])
			read_reg(cfg_reg, d);
	endtask

	task automatic fill_random(input udma_i2c_pkg::l2_addr_t base, input int n, input int idx);
		for (int i = 0; i < n; i++) begin
			tx_data[idx+i] = $random(seed);
			l2_mem[base+i] = tx_data[idx+i];
		end
	endtask

	// Every bit on the wire is what the shifter drove ANDed with the pull-down
	function automatic udma_i2c_pkg::byte_t line_byte(input udma_i2c_pkg::byte_t tx,
		input logic pulled);
		return pulled ? 8'h00 : tx;
	endfunction

	task automatic build_expected(input int count, input int period, input logic pulled);
		for (int i = 0; i < count; i++)
			exp_rx[i] = line_byte(tx_data[i % period], pulled);
	endtask

	task automatic preset_region(input udma_i2c_pkg::l2_addr_t base, input int n);
		for (int i = 0; i < n; i++)
			l2_mem[base+i] = ~exp_rx[i]; // Differs from every expected byte
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
	endtask

	task automatic check_region(input string name, input udma_i2c_pkg::l2_addr_t base,
		input int n);
		for (int i = 0; i < n; i++)
			if (l2_mem[base+i] !== exp_rx[i])
				report_mismatch($sformatf("%s[%0d]", name, i), exp_rx[i], l2_mem[base+i]);
	endtask

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------
	initial begin
		udma_i2c_pkg::cfg_addr_t base;
		udma_i2c_pkg::cfg_addr_t off;
		udma_i2c_pkg::cfg_data_t sa;
		udma_i2c_pkg::cfg_data_t sz;
		udma_i2c_pkg::cfg_data_t cf;
		udma_i2c_pkg::cfg_data_t rd;
		int n;
		int fetch_mark;
		int write_mark;
		int pulse_mark;

		rstn_i        = 1'b0;
		cfg_data_i    = '0;
		cfg_addr_i    = '0;
		cfg_valid_i   = 1'b0;
		cfg_rwn_i     = 1'b0;
		l2_tx_rdata_i = '0;
		pull_low      = 1'b0;
		for (int a = 0; a < 4096; a++)
			l2_mem[a] = a[7:0] ^ {4'h0, a[11:8]} ^ 8'h5A;
		repeat (3) @(posedge clk_i);
		#1;
		rstn_i = 1'b1;

		// Register readback on idle channels
		for (int i = 0; i < 16; i++) begin
			base = (i % 2) ? `REG_TX_SADDR : `REG_RX_SADDR;
			sa   = $random(seed);
			sz   = $random(seed);
			cf   = $random(seed) & ~32'h30; // Never start or clear here
			configure_channel(base, udma_i2c_pkg::l2_addr_t'(sa), sz, cf);
			read_reg(base, rd);
			if (rd !== (sa & ADDR_MASK))
				report_mismatch("saddr readback", sa & ADDR_MASK, rd);
			read_reg(base + 5'd1, rd);
			if (rd !== (sz & SIZE_MASK))
				report_mismatch("size readback", sz & SIZE_MASK, rd);
			read_reg(base + 5'd2, rd);
			if (rd !== (cf & 32'h1))
				report_mismatch("cfg readback", cf & 32'h1, rd);
			off = (i == 0) ? 5'd3 : (i == 1) ? 5'd7 :
				udma_i2c_pkg::cfg_addr_t'(10 + $unsigned($random(seed)) % 22);
			read_reg(off, rd);
			if (rd !== 32'h0)
				report_mismatch($sformatf("unused offset %0d", off), 32'h0, rd);
		end

		// Loopback of a random block
		n = 1 + $unsigned($random(seed)) % 8;
		fill_random(12'h100, n, 0);
		build_expected(n, n, 1'b0);
		preset_region(12'h400, n);
		pulse_mark = scl_pulses;
		configure_channel(`REG_RX_SADDR, 12'h400, n, 32'h10);
		configure_channel(`REG_TX_SADDR, 12'h100, n, 32'h10);
		wait_channel_idle(`REG_TX_CFG);
		wait_channel_idle(`REG_RX_CFG);
		check_region("loopback data", 12'h400, n);
		if (scl_pulses - pulse_mark != 8 * n)
			report_mismatch("loopback scl pulses", 8 * n, scl_pulses - pulse_mark);
		read_reg(`REG_RX_SIZE, rd);
		if (rd !== 32'h0)
			report_mismatch("loopback rx bytes_left", 32'h0, rd);
		read_reg(`REG_TX_SIZE, rd);
		if (rd !== 32'h0)
			report_mismatch("loopback tx bytes_left", 32'h0, rd);

		// Sticky status flags
		read_reg(`REG_STATUS, rd);
		if (rd !== 32'h1)
			report_mismatch("status after transfer", 32'h1, rd);
		read_reg(`REG_STATUS, rd);
		if (rd !== 32'h0)
			report_mismatch("status after clear", 32'h0, rd);
		tx_data[0]     = 8'hFF;
		l2_mem[12'h0F0] = 8'hFF;
		build_expected(1, 1, 1'b1);
		preset_region(12'h4F0, 1);
		pull_low = 1'b1;
		configure_channel(`REG_RX_SADDR, 12'h4F0, 1, 32'h10);
		configure_channel(`REG_TX_SADDR, 12'h0F0, 1, 32'h10);
		wait_channel_idle(`REG_RX_CFG);
		pull_low = 1'b0;
		check_region("pulled byte", 12'h4F0, 1);
		read_reg(`REG_STATUS, rd);
		if (rd !== 32'h3)
			report_mismatch("status with arbitration lost", 32'h3, rd);

		// Continuous transmit, stopped by clr
		n = 2 + $unsigned($random(seed)) % 3;
		fill_random(12'h200, n, 0);
		build_expected(2 * n, n, 1'b0);
		preset_region(12'h600, 2 * n);
		configure_channel(`REG_RX_SADDR, 12'h600, 2 * n, 32'h10);
		configure_channel(`REG_TX_SADDR, 12'h200, n, 32'h11);
		wait_channel_idle(`REG_RX_CFG);
		write_reg(`REG_TX_CFG, 32'h20);
		idle_cycles(2);
		fetch_mark = fetches;
		read_reg(`REG_TX_CFG, rd);
		if (rd !== 32'h0)
			report_mismatch("tx cfg after clr", 32'h0, rd);
		idle_cycles(150);
		if (fetches != fetch_mark) begin
			fails++;
			$display("TX channel kept reading L2 after it was cleared");
		end
		check_region("continuous data", 12'h600, 2 * n);

		// Second start queued behind a running transfer
		n = 2 + $unsigned($random(seed)) % 3;
		fill_random(12'h300, n, 0);
		fill_random(12'h380, n, n);
		build_expected(2 * n, 2 * n, 1'b0);
		preset_region(12'h700, 2 * n);
		configure_channel(`REG_RX_SADDR, 12'h700, 2 * n, 32'h10);
		configure_channel(`REG_TX_SADDR, 12'h300, n, 32'h10);
		idle_cycles(5);
		write_reg(`REG_TX_SADDR, 32'h380);
		write_reg(`REG_TX_CFG, 32'h10);
		idle_cycles(2);
		read_reg(`REG_TX_CFG, rd);
		if (rd !== 32'h30)
			report_mismatch("tx cfg with pending start", 32'h30, rd);
		wait_channel_idle(`REG_RX_CFG);
		check_region("pending data", 12'h700, 2 * n);
		read_reg(`REG_TX_CFG, rd);
		if (rd !== 32'h0)
			report_mismatch("tx cfg after pending run", 32'h0, rd);

		// Soft reset in the middle of a transfer
		fill_random(12'h500, 8, 0);
		configure_channel(`REG_RX_SADDR, 12'h780, 8, 32'h10);
		configure_channel(`REG_TX_SADDR, 12'h500, 8, 32'h10);
		idle_cycles(100);
		write_reg(`REG_SETUP, 32'h1);
		idle_cycles(2);
		fetch_mark = fetches;
		write_mark = rx_writes;
		idle_cycles(150);
		if (fetches != fetch_mark || rx_writes != write_mark) begin
			fails++;
			$display("L2 requests went on while soft reset was held");
		end
		read_reg(`REG_SETUP, rd);
		if (rd !== 32'h1)
			report_mismatch("setup readback", 32'h1, rd);
		write_reg(`REG_SETUP, 32'h0);
		idle_cycles(2);
		read_reg(`REG_TX_CFG, rd);
		if (rd !== 32'h0)
			report_mismatch("tx cfg after soft reset", 32'h0, rd);
		read_reg(`REG_RX_CFG, rd);
		if (rd !== 32'h0)
			report_mismatch("rx cfg after soft reset", 32'h0, rd);

		$display("Value mismatches: %0d, other failures: %0d", errors, fails);
		if (errors == 0 && fails == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
